//--- sim.f
hdl/his_pkg.sv
hdl/his_frame_counter.sv
hdl/his_ctrl_fsm.sv
hdl/his_bank_ram.sv
hdl/his_readout.sv
hdl/his_builder_top.sv
tb/tb_his_builder.sv

//--- Makefile
# Verilator build for the histogram builder testbench

VERILATOR ?= verilator
TOP       ?= tb_his_builder
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		echo "run result: passed"; \
	else \
		echo "run result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_his_builder.sv
`timescale 1ns/1ps

module tb_his_builder import his_pkg::*; ();

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_ROWS        = 6;
    // watchdog budget per hit and per bin
    localparam int CYCLES_PER_ITEM = 40;

    // one scenario per row
    typedef struct {
        int scen;
        int n_hist;
        int p_valid;
        int p_ready;
        int rep;
        int reset_at;
    } row_t;

    logic   clk;
    logic   res;
    logic   hit_valid;
    logic   hit_ready;
    bin_t   hit_bin;
    logic   out_valid;
    logic   out_ready;
    bin_t   out_bin;
    count_t out_count;
    logic   out_last;
    logic   out_bank;

    row_t table_rows [NUM_ROWS];
    int   seed = 89219;

    // reference histogram being filled, finished ones queued bin by bin
    count_t cur_hist [BIN_NUM];
    int     cur_hits;
    count_t exp_q [$];
    int     exp_bin;
    logic   exp_bank;

    // row progress
    int   accepted;
    int   target_hits;
    int   out_done;
    logic saw_stall;
    int   rep_left;
    bin_t run_bin;
    // predicted for the next rising edge
    logic hit_wait;
    logic out_hold;
    bin_t   hold_bin;
    count_t hold_count;
    logic   hold_last;
    logic   hold_bank;

    // watchdog state
    int cycle_cnt = 0;
    int row_start = 0;
    int row_limit = 2 * RESET_CYCLES * CYCLES_PER_ITEM;
    int cur_scen  = 0;

    his_builder_top DUT (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_ready (hit_ready),
        .hit_bin   (hit_bin),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bin   (out_bin),
        .out_count (out_count),
        .out_last  (out_last),
        .out_bank  (out_bank)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input count_t got, input count_t want);
        if (got !== want) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_bin(input string name, input bin_t got, input bin_t want);
        if (got !== want) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    // watchdog, budget restarts with each row
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt - row_start > row_limit) begin
            $display("timeout: scenario %0d did not finish within %0d cycles", cur_scen,
                     row_limit);
            abort_run();
        end
    end

    // everything in flight is dropped by a reset
    task automatic clear_model();
        int b;
        for (b = 0; b < BIN_NUM; b++) begin
            cur_hist[b] = '0;
        end
        cur_hits = 0;
        exp_q.delete();
        exp_bin  = 0;
        // first bank read after reset is tagged 1
        exp_bank = 1'b1;
        hit_wait = 1'b0;
        out_hold = 1'b0;
        rep_left = 0;
    endtask

    task automatic record_hit(input bin_t bin);
        int b;
        accepted++;
        cur_hist[bin] = cur_hist[bin] + count_t'(1);
        cur_hits++;
        // histogram complete, queue it for the output side
        if (cur_hits == HITS_PER_HIST) begin
            for (b = 0; b < BIN_NUM; b++) begin
                exp_q.push_back(cur_hist[b]);
                cur_hist[b] = '0;
            end
            cur_hits = 0;
        end
    endtask

    task automatic check_output();
        count_t want;
        if (exp_q.size() == 0) begin
            $display("output transfer seen while no finished histogram was expected");
            abort_run();
        end else begin
            want = exp_q.pop_front();
            check_bin("out_bin", out_bin, bin_t'(exp_bin));
            check_count("out_count", out_count, want);
            check_flag("out_last", out_last, exp_bin == BIN_NUM - 1);
            check_flag("out_bank", out_bank, exp_bank);
            out_done++;
            if (exp_bin == BIN_NUM - 1) begin
                exp_bin  = 0;
                exp_bank = ~exp_bank;
            end else begin
                exp_bin++;
            end
        end
    endtask

    task automatic drive_cycle(input row_t row);
        int rnd;
        @(negedge clk);
        // stalled output must not move
        if (out_hold) begin
            check_flag("out_valid", out_valid, 1'b1);
            check_bin("out_bin", out_bin, hold_bin);
            check_count("out_count", out_count, hold_count);
            check_flag("out_last", out_last, hold_last);
            check_flag("out_bank", out_bank, hold_bank);
        end
        // a waiting hit stays on the bus unchanged
        if (!hit_wait) begin
            hit_valid = 1'b0;
            rnd = $random(seed) & 32'h7fff_ffff;
            if (accepted < target_hits && rnd % 100 < row.p_valid) begin
                // new bin after a run of rep hits
                if (rep_left == 0) begin
                    run_bin  = bin_t'($random(seed));
                    rep_left = row.rep;
                end
                rep_left  = rep_left - 1;
                hit_valid = 1'b1;
                hit_bin   = run_bin;
            end
        end
        rnd = $random(seed) & 32'h7fff_ffff;
        out_ready = (rnd % 100 < row.p_ready);
        // registered outputs, so this is what the next edge sees
        if (!hit_ready) begin
            saw_stall = 1'b1;
        end
        hit_wait = hit_valid & ~hit_ready;
        if (hit_valid && hit_ready) begin
            record_hit(hit_bin);
        end
        out_hold = out_valid & ~out_ready;
        if (out_hold) begin
            hold_bin   = out_bin;
            hold_count = out_count;
            hold_last  = out_last;
            hold_bank  = out_bank;
        end
        if (out_valid && out_ready) begin
            check_output();
        end
    endtask

    // caller sits on a falling edge with no prediction pending
    task automatic apply_reset(input int cycles);
        int i;
        res       = 1'b0;
        hit_valid = 1'b0;
        out_ready = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_flag("hit_ready", hit_ready, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
        end
        res = 1'b1;
        @(negedge clk);
        // input opens one cycle after release
        check_flag("hit_ready", hit_ready, 1'b1);
        clear_model();
    endtask

    task automatic run_row(input row_t row);
        cur_scen    = row.scen;
        target_hits = row.n_hist * HITS_PER_HIST;
        row_start   = cycle_cnt;
        row_limit   = (target_hits + row.n_hist * BIN_NUM + row.reset_at) * CYCLES_PER_ITEM;
        accepted    = 0;
        out_done    = 0;
        saw_stall   = 1'b0;
        rep_left    = 0;
        // reset partway, then the row starts over
        if (row.reset_at > 0) begin
            while (accepted < row.reset_at) begin
                drive_cycle(row);
            end
            @(negedge clk);
            apply_reset(4);
            accepted = 0;
            out_done = 0;
        end
        while (accepted < target_hits || out_done < row.n_hist * BIN_NUM) begin
            drive_cycle(row);
        end
        // slow sink must have pushed back on the input
        if (row.p_ready < 10) begin
            check_flag("hit_ready stall seen", saw_stall, 1'b1);
        end
    endtask

    initial begin
        int r;
        clk       = 1'b0;
        res       = 1'b0;
        hit_valid = 1'b0;
        hit_bin   = '0;
        out_ready = 1'b0;
        // scen, histograms, hit_valid %, out_ready %, same-bin run, reset after hits
        table_rows[0] = '{1, 3, 100, 100, 1, 0};
        table_rows[1] = '{2, 4, 60, 80, 1, 0};
        table_rows[2] = '{3, 3, 100, 5, 1, 0};
        table_rows[3] = '{4, 2, 100, 100, 24, 0};
        table_rows[4] = '{5, 2, 70, 50, 3, 0};
        table_rows[5] = '{6, 2, 100, 30, 1, 30};
        apply_reset(RESET_CYCLES);
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(table_rows[r]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- hdl/his_builder_top.sv
`timescale 1ns/1ps

module his_builder_top import his_pkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   hit_valid,
    output logic   hit_ready,
    input  bin_t   hit_bin,
    output logic   out_valid,
    input  logic   out_ready,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last,
    output logic   out_bank
);

    // accepted hit
    logic hit_fire;
    // final hit of a histogram
    logic hist_last;
    // collecting bank
    logic acc_bank;
    // readout handshake with controller
    logic read_start;
    logic read_busy;
    // streamer side of the banks
    logic   rd_en;
    bin_t   rd_addr;
    count_t rd_count;

    assign hit_fire = hit_valid & hit_ready;

    // hit, pixel and acquisition levels
    his_frame_counter u_frame_counter (
        .clk       (clk),
        .res       (res),
        .hit_fire  (hit_fire),
        .hist_last (hist_last)
    );

    // bank ownership and swap
    his_ctrl_fsm u_ctrl_fsm (
        .clk        (clk),
        .res        (res),
        .hit_fire   (hit_fire),
        .hist_last  (hist_last),
        .read_busy  (read_busy),
        .hit_ready  (hit_ready),
        .acc_bank   (acc_bank),
        .read_start (read_start)
    );

    // ping-pong histogram banks
    his_bank_ram u_bank_ram (
        .clk      (clk),
        .res      (res),
        .hit_fire (hit_fire),
        .hit_bin  (hit_bin),
        .acc_bank (acc_bank),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_count (rd_count)
    );

    // finished bank out over valid/ready
    his_readout u_readout (
        .clk        (clk),
        .res        (res),
        .read_start (read_start),
        .acc_bank   (acc_bank),
        .rd_count   (rd_count),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .read_busy  (read_busy),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last),
        .out_bank   (out_bank)
    );

endmodule

//--- hdl/his_readout.sv
`timescale 1ns/1ps

module his_readout import his_pkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   read_start,
    input  logic   acc_bank,
    input  count_t rd_count,
    output logic   rd_en,
    output bin_t   rd_addr,
    output logic   read_busy,
    output logic   out_valid,
    input  logic   out_ready,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last,
    output logic   out_bank
);

    localparam bin_t LAST_BIN = BIN_W'(BIN_NUM - 1);

    // streaming in progress
    logic busy_q;
    // bins left to load
    logic load_pend;
    // handshake on the output
    logic xfer;

    assign xfer = out_valid & out_ready;

    // load only into an empty register, one bin per two cycles at most
    assign rd_en = load_pend & ~out_valid;

    // covers the start pulse cycle too
    assign read_busy = busy_q | read_start;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy_q    <= 1'b0;
            load_pend <= 1'b0;
            rd_addr   <= '0;
            out_valid <= 1'b0;
            out_bank  <= 1'b0;
        end else begin
            if (read_start) begin
                busy_q    <= 1'b1;
                load_pend <= 1'b1;
                rd_addr   <= '0;
                // bank tag follows the hisNum toggle, 1 on the first histogram
                out_bank  <= acc_bank;
            end else if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
                // final bin loaded
                if (rd_addr == LAST_BIN) begin
                    load_pend <= 1'b0;
                end
            end
            if (rd_en) begin
                out_valid <= 1'b1;
            end else if (xfer) begin
                out_valid <= 1'b0;
            end
            // done after the last bin is taken
            if (xfer && out_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // output payload, held until taken
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_bin   <= rd_addr;
            out_count <= rd_count;
            out_last  <= (rd_addr == LAST_BIN);
        end
    end

endmodule

//--- hdl/his_bank_ram.sv
`timescale 1ns/1ps

module his_bank_ram import his_pkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   hit_fire,
    input  bin_t   hit_bin,
    input  logic   acc_bank,
    input  logic   rd_en,
    input  bin_t   rd_addr,
    output count_t rd_count
);

    // two histogram banks as register arrays
    count_t mem [2][BIN_NUM];

    // increment stage, one hit in flight
    logic   wr_pend;
    bin_t   wr_bin;
    logic   wr_bank;
    count_t wr_val;

    // repeat of the in-flight bin
    logic   fwd;
    count_t old_val;
    count_t inc_val;

    // bank not collecting
    logic rd_bank;

    assign fwd = wr_pend && (wr_bank == acc_bank) && (wr_bin == hit_bin);

    // in-flight value is newer than the array
    assign old_val = fwd ? wr_val : mem[acc_bank][hit_bin];
    assign inc_val = old_val + 1'b1;

    assign rd_bank  = ~acc_bank;
    // combinational read for the streamer
    assign rd_count = mem[rd_bank][rd_addr];

    // pending flag
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= hit_fire;
        end
    end

    // stage payload, bank latched with the hit
    always_ff @(posedge clk) begin
        if (hit_fire) begin
            wr_bin  <= hit_bin;
            wr_bank <= acc_bank;
            wr_val  <= inc_val;
        end
    end

    // array update
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < BIN_NUM; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            // write back the incremented count one edge after acceptance
            if (wr_pend) begin
                mem[wr_bank][wr_bin] <= wr_val;
            end
            // clear on read, so the bank starts empty next time it collects
            if (rd_en) begin
                mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

endmodule

//--- hdl/his_ctrl_fsm.sv
`timescale 1ns/1ps

module his_ctrl_fsm import his_pkg::*; (
    input  logic clk,
    input  logic res,
    input  logic hit_fire,
    input  logic hist_last,
    input  logic read_busy,
    output logic hit_ready,
    output logic acc_bank,
    output logic read_start
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // bank swap this cycle
    logic swap;

    always_comb begin
        state_nxt = state;
        swap      = 1'b0;
        case (state)
            COLLECT, COLLECT_READ: begin
                if (hit_fire && hist_last) begin
                    if (read_busy) begin
                        // other bank still streaming, hold the input
                        state_nxt = STALL;
                    end else begin
                        swap      = 1'b1;
                        state_nxt = COLLECT_READ;
                    end
                end else if (!read_busy) begin
                    // readout finished, back to plain collecting
                    state_nxt = COLLECT;
                end
            end
            STALL: begin
                // swap as soon as the streamer lets go
                if (!read_busy) begin
                    swap      = 1'b1;
                    state_nxt = COLLECT_READ;
                end
            end
            default: begin
                state_nxt = COLLECT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= COLLECT;
            hit_ready  <= 1'b0;
            acc_bank   <= 1'b0;
            read_start <= 1'b0;
        end else begin
            state      <= state_nxt;
            // input only blocked while stalled
            hit_ready  <= (state_nxt != STALL);
            // ping-pong toggle, like hisNum
            acc_bank   <= acc_bank ^ swap;
            // one cycle after the swap edge
            read_start <= swap;
        end
    end

endmodule

//--- hdl/his_frame_counter.sv
`timescale 1ns/1ps

module his_frame_counter import his_pkg::*; (
    input  logic clk,
    input  logic res,
    input  logic hit_fire,
    output logic hist_last
);

    // last value of each level
    localparam logic [HIT_W-1:0] HIT_MAX = HIT_W'(HITS_PER_PIXEL - 1);
    localparam logic [PIX_W-1:0] PIX_MAX = PIX_W'(PIXELS_PER_ACQ - 1);
    localparam logic [ACQ_W-1:0] ACQ_MAX = ACQ_W'(ACQS_PER_HIST - 1);

    // nested counters, innermost first
    logic [HIT_W-1:0] hit_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    // each level sitting at its last value
    logic hit_end;
    logic pix_end;
    logic acq_end;

    assign hit_end = (hit_cnt == HIT_MAX);
    assign pix_end = (pix_cnt == PIX_MAX);
    assign acq_end = (acq_cnt == ACQ_MAX);

    // high while the final hit of the histogram is being accepted
    assign hist_last = hit_fire & hit_end & pix_end & acq_end;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (hit_fire) begin
            if (!hit_end) begin
                // still inside the pixel
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                // pixel done, step to next pixel
                hit_cnt <= '0;
                if (!pix_end) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    // acquisition done
                    pix_cnt <= '0;
                    if (!acq_end) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        // histogram done, all levels wrap together
                        acq_cnt <= '0;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/his_pkg.sv
package his_pkg;

    // frame geometry
    // hits land per pixel, pixels per acquisition, acquisitions per histogram
    localparam int HITS_PER_PIXEL = 2;
    localparam int PIXELS_PER_ACQ = 4;
    localparam int ACQS_PER_HIST  = 3;

    // total hits in one histogram
    localparam int HITS_PER_HIST = HITS_PER_PIXEL * PIXELS_PER_ACQ * ACQS_PER_HIST;

    // time bins per histogram
    localparam int BIN_NUM = 16;
    localparam int BIN_W   = $clog2(BIN_NUM);

    // wide enough for every hit landing in one bin, so no saturation
    localparam int COUNT_W = $clog2(HITS_PER_HIST + 1);

    // level counter widths, at least one bit each
    localparam int HIT_W = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int PIX_W = (PIXELS_PER_ACQ > 1) ? $clog2(PIXELS_PER_ACQ) : 1;
    localparam int ACQ_W = (ACQS_PER_HIST > 1) ? $clog2(ACQS_PER_HIST) : 1;

    // bin index and bin count
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [COUNT_W-1:0] count_t;

    // bank controller states
    // COLLECT       collecting, readout idle
    // COLLECT_READ  collecting while the other bank streams out
    // STALL         collecting bank full, other bank still streaming
    typedef enum logic [1:0] {
        COLLECT      = 2'd0,
        COLLECT_READ = 2'd1,
        STALL        = 2'd2
    } ctrl_state_t;

endpackage
